// ==== include/motor_consts.svh ====
`ifndef MOTOR_CONSTS_SVH
`define MOTOR_CONSTS_SVH

// Command word and SPI frame
`define MOTOR_DATA_W        32
`define MOTOR_OP_W          8
`define MOTOR_FRAME_BITS    40  // Opcode byte then data word
`define MOTOR_BITCNT_W      6

// Config fields
`define MOTOR_CURRENT_W     8
`define MOTOR_USTEP_W       3
`define MOTOR_MICROSTEP_MAX 6

// Electrical angle, 256 counts per cycle
`define MOTOR_PHASE_W       8
`define MOTOR_FULL_STEP     8'd64

// Free-running PWM
`define MOTOR_PWM_W         8
`define MOTOR_PWM_PERIOD    256

// Opcode codes
`define MOTOR_OP_NOP              8'h00
`define MOTOR_OP_SET_CURRENT      8'h01
`define MOTOR_OP_SET_MICROSTEPS   8'h02
`define MOTOR_OP_SET_DRIVE_ENABLE 8'h03
`define MOTOR_OP_READ_CONFIG      8'h10
`define MOTOR_OP_READ_POSITION    8'h11
`define MOTOR_OP_READ_ENCODER     8'h12
`define MOTOR_OP_READ_STATUS      8'h13

`endif

// ==== source/motor_pkg.sv ====
`include "motor_consts.svh"

package motor_pkg;

  // Writes below 8'h10, reads from 8'h10 up
  typedef enum logic [`MOTOR_OP_W-1:0] {
    op_nop              = `MOTOR_OP_NOP,
    op_set_current      = `MOTOR_OP_SET_CURRENT,
    op_set_microsteps   = `MOTOR_OP_SET_MICROSTEPS,
    op_set_drive_enable = `MOTOR_OP_SET_DRIVE_ENABLE,
    op_read_config      = `MOTOR_OP_READ_CONFIG,
    op_read_position    = `MOTOR_OP_READ_POSITION,
    op_read_encoder     = `MOTOR_OP_READ_ENCODER,
    op_read_status      = `MOTOR_OP_READ_STATUS
  } spi_opcode_t;

  typedef enum logic [1:0] {
    spi_idle,
    spi_opcode,
    spi_data,
    spi_done
  } spi_state_t;

  typedef struct packed {
    logic [`MOTOR_CURRENT_W-1:0] current;     // Coil amplitude at full step
    logic [`MOTOR_USTEP_W-1:0]   microsteps;  // Step size is 64 >> microsteps
    logic                        drive_enable;
  } motor_config_t;

  // Pin commands after synchronizing
  typedef struct packed {
    logic step_pulse;
    logic dir;
    logic enable;
  } step_cmd_t;

  typedef struct packed {
    logic [`MOTOR_PHASE_W-1:0] phase;
    logic                      active;
  } coil_drive_t;

endpackage

// ==== source/spi_cmd_port.sv ====
`timescale 1ns/1ps
`include "motor_consts.svh"

module spi_cmd_port (
  input  logic                            CLK,
  input  logic                            resetn,
  input  logic                            sck,
  input  logic                            cs,
  input  logic                            copi,
  input  logic signed [`MOTOR_DATA_W-1:0] position,
  input  logic signed [`MOTOR_DATA_W-1:0] enc_count,
  input  logic                            enc_fault,
  input  logic                            drive_active,
  output logic                            cipo,
  output motor_pkg::motor_config_t        cfg
);

  logic [2:0] sck_sync;
  logic [1:0] cs_sync;
  logic [1:0] copi_sync;
  logic       sck_rise;
  logic       sck_fall;
  logic       cs_n;
  logic       copi_bit;

  motor_pkg::spi_state_t          state;
  logic [`MOTOR_BITCNT_W-1:0]     bit_cnt;
  logic [`MOTOR_FRAME_BITS-1:0]   frame;
  logic [`MOTOR_DATA_W-1:0]       tx_shift;
  logic [`MOTOR_OP_W-1:0]         rx_op;
  logic [`MOTOR_OP_W-1:0]         wr_op;
  logic [`MOTOR_DATA_W-1:0]       wr_data;
  logic [`MOTOR_DATA_W-1:0]       rd_data;
  logic                           op_last;

  // SCK gets a third stage for edge detect
  assign sck_rise = sck_sync[1] & ~sck_sync[2];
  assign sck_fall = ~sck_sync[1] & sck_sync[2];
  assign cs_n     = cs_sync[1];
  assign copi_bit = copi_sync[1];

  // Eighth bit completes the opcode
  assign op_last = (state == motor_pkg::spi_opcode) && sck_rise &&
                   (bit_cnt == `MOTOR_OP_W - 1);
  assign rx_op   = {frame[`MOTOR_OP_W-2:0], copi_bit};

  assign wr_op   = frame[`MOTOR_FRAME_BITS-1 -: `MOTOR_OP_W];
  assign wr_data = frame[`MOTOR_DATA_W-1:0];

  always_comb begin
    case (motor_pkg::spi_opcode_t'(rx_op))
      motor_pkg::op_read_config:
        rd_data = {15'd0, cfg.drive_enable, 5'd0, cfg.microsteps, cfg.current};
      motor_pkg::op_read_position: rd_data = position;
      motor_pkg::op_read_encoder:  rd_data = enc_count;
      motor_pkg::op_read_status:   rd_data = {30'd0, drive_active, enc_fault};
      default:                     rd_data = '0;  // Writes shift out zeros
    endcase
  end

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      sck_sync  <= '0;
      cs_sync   <= '1;
      copi_sync <= '0;
    end else begin
      sck_sync  <= {sck_sync[1:0], sck};
      cs_sync   <= {cs_sync[0], cs};
      copi_sync <= {copi_sync[0], copi};
    end
  end

  // Receive and transmit shift registers
  always_ff @(posedge CLK) begin
    if (sck_rise && (state == motor_pkg::spi_opcode || state == motor_pkg::spi_data))
      frame <= {frame[`MOTOR_FRAME_BITS-2:0], copi_bit};
    if (op_last)
      tx_shift <= rd_data;
    else if (sck_fall && state == motor_pkg::spi_data)
      tx_shift <= {tx_shift[`MOTOR_DATA_W-2:0], 1'b0};
  end

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      state   <= motor_pkg::spi_idle;
      bit_cnt <= '0;
      cipo    <= 1'b0;
      cfg     <= '0;
    end else if (cs_n) begin
      // Frame end; a write counts only with exactly 40 bits
      if (state == motor_pkg::spi_done && bit_cnt == `MOTOR_FRAME_BITS) begin
        case (motor_pkg::spi_opcode_t'(wr_op))
          motor_pkg::op_set_current:
            cfg.current <= wr_data[`MOTOR_CURRENT_W-1:0];
          motor_pkg::op_set_microsteps:
            cfg.microsteps <= (wr_data > `MOTOR_MICROSTEP_MAX) ?
                              `MOTOR_USTEP_W'(`MOTOR_MICROSTEP_MAX) :
                              wr_data[`MOTOR_USTEP_W-1:0];
          motor_pkg::op_set_drive_enable:
            cfg.drive_enable <= wr_data[0];
          default: ;
        endcase
      end
      state <= motor_pkg::spi_idle;
      cipo  <= 1'b0;
    end else begin
      case (state)
        motor_pkg::spi_idle: begin
          state   <= motor_pkg::spi_opcode;
          bit_cnt <= '0;
        end
        motor_pkg::spi_opcode: begin
          if (sck_rise) begin
            bit_cnt <= bit_cnt + 1'b1;
            if (op_last)
              state <= motor_pkg::spi_data;
          end
        end
        motor_pkg::spi_data: begin
          if (sck_rise) begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == `MOTOR_FRAME_BITS - 1)
              state <= motor_pkg::spi_done;
          end
          if (sck_fall)
            cipo <= tx_shift[`MOTOR_DATA_W-1];  // MSB first
        end
        motor_pkg::spi_done: begin
          // One extra bit is enough to spoil the frame
          if (sck_rise && bit_cnt == `MOTOR_FRAME_BITS)
            bit_cnt <= bit_cnt + 1'b1;
          if (sck_fall)
            cipo <= 1'b0;
        end
        default: state <= motor_pkg::spi_idle;
      endcase
    end
  end

endmodule

// ==== source/step_sequencer.sv ====
`timescale 1ns/1ps
`include "motor_consts.svh"

module step_sequencer (
  input  logic                             CLK,
  input  logic                             resetn,
  input  logic                             step,
  input  logic                             dir,
  input  logic                             enable,
  input  motor_pkg::motor_config_t         cfg,
  output logic signed [`MOTOR_DATA_W-1:0]  position,
  output logic                             drive_active,
  output motor_pkg::coil_drive_t           coil
);

  logic [1:0]                step_sync;
  logic [1:0]                dir_sync;
  logic [1:0]                en_sync;
  logic                      step_prev;
  motor_pkg::step_cmd_t      cmd;
  logic [`MOTOR_PHASE_W-1:0] phase;
  logic [`MOTOR_PHASE_W-1:0] step_size;

  assign cmd.step_pulse = step_sync[1] & ~step_prev;  // Rising edge only
  assign cmd.dir        = dir_sync[1];
  assign cmd.enable     = en_sync[1];

  assign drive_active = cmd.enable & cfg.drive_enable;
  assign step_size    = `MOTOR_FULL_STEP >> cfg.microsteps;

  assign coil.phase  = phase;
  assign coil.active = drive_active;

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      step_sync <= '0;
      dir_sync  <= '0;
      en_sync   <= '0;
      step_prev <= 1'b0;
      position  <= '0;
      phase     <= '0;
    end else begin
      step_sync <= {step_sync[0], step};
      dir_sync  <= {dir_sync[0], dir};
      en_sync   <= {en_sync[0], enable};
      step_prev <= step_sync[1];
      if (cmd.step_pulse && drive_active) begin
        // Phase wraps modulo one electrical cycle
        if (cmd.dir) begin
          position <= position + 32'sd1;
          phase    <= phase + step_size;
        end else begin
          position <= position - 32'sd1;
          phase    <= phase - step_size;
        end
      end
    end
  end

endmodule

// ==== source/quad_decoder.sv ====
`timescale 1ns/1ps
`include "motor_consts.svh"

module quad_decoder (
  input  logic                            CLK,
  input  logic                            resetn,
  input  logic                            enc_a,
  input  logic                            enc_b,
  output logic signed [`MOTOR_DATA_W-1:0] count,
  output logic                            fault
);

  logic [1:0] a_sync;
  logic [1:0] b_sync;
  logic [1:0] cur_ab;
  logic [1:0] prev_ab;

  assign cur_ab = {a_sync[1], b_sync[1]};

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      a_sync  <= '0;
      b_sync  <= '0;
      prev_ab <= '0;
      count   <= '0;
      fault   <= 1'b0;
    end else begin
      a_sync  <= {a_sync[0], enc_a};
      b_sync  <= {b_sync[0], enc_b};
      prev_ab <= cur_ab;
      // Forward has A leading B, 00 -> 10 -> 11 -> 01
      case ({prev_ab, cur_ab})
        4'b0010,
        4'b1011,
        4'b1101,
        4'b0100: count <= count + 32'sd1;
        4'b0001,
        4'b0111,
        4'b1110,
        4'b1000: count <= count - 32'sd1;
        4'b0011,
        4'b0110,
        4'b1001,
        4'b1100: fault <= 1'b1;  // Both edges at once, sticky until reset
        default: ;               // No change
      endcase
    end
  end

endmodule

// ==== source/phase_driver.sv ====
`timescale 1ns/1ps
`include "motor_consts.svh"

module phase_driver (
  input  logic                     CLK,
  input  logic                     resetn,
  input  motor_pkg::coil_drive_t   coil,
  input  motor_pkg::motor_config_t cfg,
  output logic                     phase_a1,
  output logic                     phase_a2,
  output logic                     phase_b1,
  output logic                     phase_b2
);

  // Quarter sine scaled to 256, entry 64 is the peak
  localparam logic [8:0] sine_tab [0:64] = '{
    9'd0,   9'd6,   9'd13,  9'd19,  9'd25,  9'd31,  9'd38,  9'd44,
    9'd50,  9'd56,  9'd62,  9'd68,  9'd74,  9'd80,  9'd86,  9'd92,
    9'd98,  9'd104, 9'd109, 9'd115, 9'd121, 9'd126, 9'd132, 9'd137,
    9'd142, 9'd147, 9'd152, 9'd157, 9'd162, 9'd167, 9'd172, 9'd177,
    9'd181, 9'd185, 9'd190, 9'd194, 9'd198, 9'd202, 9'd206, 9'd209,
    9'd213, 9'd216, 9'd220, 9'd223, 9'd226, 9'd229, 9'd231, 9'd234,
    9'd237, 9'd239, 9'd241, 9'd243, 9'd245, 9'd247, 9'd248, 9'd250,
    9'd251, 9'd252, 9'd253, 9'd254, 9'd255, 9'd255, 9'd256, 9'd256,
    9'd256
  };

  logic [1:0]              quad;
  logic [5:0]              offs;
  logic [6:0]              idx_fwd;
  logic [6:0]              idx_rev;
  logic [8:0]              mag_a;
  logic [8:0]              mag_b;
  logic                    neg_a;
  logic                    neg_b;
  logic [15:0]             prod_a;
  logic [15:0]             prod_b;
  logic [`MOTOR_PWM_W-1:0] pwm_cnt;
  logic [`MOTOR_PWM_W-1:0] amp_a_q;
  logic [`MOTOR_PWM_W-1:0] amp_b_q;
  logic                    neg_a_q;
  logic                    neg_b_q;

  assign quad    = coil.phase[`MOTOR_PHASE_W-1 -: 2];
  assign offs    = coil.phase[5:0];
  assign idx_fwd = {1'b0, offs};
  assign idx_rev = 7'd64 - idx_fwd;

  // Coil A follows cosine, coil B follows sine
  assign mag_a = sine_tab[quad[0] ? idx_fwd : idx_rev];
  assign mag_b = sine_tab[quad[0] ? idx_rev : idx_fwd];
  assign neg_a = quad[1] ^ quad[0];  // Quadrants 1 and 2
  assign neg_b = quad[1];            // Quadrants 2 and 3

  // Peak 256 * 255 still fits in 16 bits
  assign prod_a = mag_a * cfg.current;
  assign prod_b = mag_b * cfg.current;

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      pwm_cnt  <= '0;
      amp_a_q  <= '0;
      amp_b_q  <= '0;
      neg_a_q  <= 1'b0;
      neg_b_q  <= 1'b0;
      phase_a1 <= 1'b0;
      phase_a2 <= 1'b0;
      phase_b1 <= 1'b0;
      phase_b2 <= 1'b0;
    end else begin
      pwm_cnt <= pwm_cnt + 1'b1;
      if (&pwm_cnt) begin  // New duty from the next period
        amp_a_q <= prod_a[15:8];
        amp_b_q <= prod_b[15:8];
        neg_a_q <= neg_a;
        neg_b_q <= neg_b;
      end
      phase_a1 <= coil.active & ~neg_a_q & (pwm_cnt < amp_a_q);
      phase_a2 <= coil.active & neg_a_q & (pwm_cnt < amp_a_q);
      phase_b1 <= coil.active & ~neg_b_q & (pwm_cnt < amp_b_q);
      phase_b2 <= coil.active & neg_b_q & (pwm_cnt < amp_b_q);
    end
  end

endmodule

// ==== source/motor_core.sv ====
`timescale 1ns/1ps
`include "motor_consts.svh"

module motor_core (
  input  logic CLK,
  input  logic resetn,
  input  logic sck,
  input  logic cs,
  input  logic copi,
  input  logic step,
  input  logic dir,
  input  logic enable,
  input  logic enc_a,
  input  logic enc_b,
  output logic cipo,
  output logic phase_a1,
  output logic phase_a2,
  output logic phase_b1,
  output logic phase_b2
);

  motor_pkg::motor_config_t        cfg;
  motor_pkg::coil_drive_t          coil;
  logic signed [`MOTOR_DATA_W-1:0] position;
  logic signed [`MOTOR_DATA_W-1:0] enc_count;
  logic                            enc_fault;
  logic                            drive_active;

  // Config and readback
  spi_cmd_port u_spi (
    .CLK          (CLK),
    .resetn       (resetn),
    .sck          (sck),
    .cs           (cs),
    .copi         (copi),
    .position     (position),
    .enc_count    (enc_count),
    .enc_fault    (enc_fault),
    .drive_active (drive_active),
    .cipo         (cipo),
    .cfg          (cfg)
  );

  step_sequencer u_seq (
    .CLK          (CLK),
    .resetn       (resetn),
    .step         (step),
    .dir          (dir),
    .enable       (enable),
    .cfg          (cfg),
    .position     (position),
    .drive_active (drive_active),
    .coil         (coil)
  );

  quad_decoder u_enc (
    .CLK    (CLK),
    .resetn (resetn),
    .enc_a  (enc_a),
    .enc_b  (enc_b),
    .count  (enc_count),
    .fault  (enc_fault)
  );

  // Two H-bridge coils
  phase_driver u_drv (
    .CLK      (CLK),
    .resetn   (resetn),
    .coil     (coil),
    .cfg      (cfg),
    .phase_a1 (phase_a1),
    .phase_a2 (phase_a2),
    .phase_b1 (phase_b1),
    .phase_b2 (phase_b2)
  );

endmodule

// ==== dv/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
  output logic CLK,
  output logic resetn
);

  localparam int half_period = 10;  // 20 ns clock

  initial begin
    CLK = 1'b0;
    forever #(half_period) CLK = ~CLK;
  end

  // Reset held low over the first 5 cycles
  initial begin
    resetn = 1'b0;
    repeat (5) @(posedge CLK);
    #2;
    resetn = 1'b1;
  end

endmodule

// ==== dv/motor_checker.sv ====
`timescale 1ns/1ps
`include "motor_consts.svh"

module motor_checker (
  input logic CLK,
  input logic sck,
  input logic cs,
  input logic cipo,
  input logic phase_a1,
  input logic phase_a2,
  input logic phase_b1,
  input logic phase_b2
);

  int          read_errors = 0;
  int          duty_errors = 0;
  int          checks = 0;
  int          sck_rises = 0;
  int          frames_done = 0;
  int          frames_taken = 0;
  logic [31:0] rd_word;
  logic [31:0] last_word;

  // Frame start clears the count, data bits follow the opcode byte
  always @(negedge cs or posedge sck) begin
    if (!sck) begin
      sck_rises = 0;
    end else if (!cs) begin
      sck_rises++;
      if (sck_rises > `MOTOR_OP_W)
        rd_word = {rd_word[30:0], cipo};  // MSB first
    end
  end

  always @(posedge cs) begin
    if (sck_rises == `MOTOR_FRAME_BITS) begin
      last_word = rd_word;
      frames_done++;
    end
  end

  task automatic check_read(input string name, input logic [31:0] exp);
    checks++;
    if (frames_done == frames_taken) begin
      read_errors++;
      $display("Read %s finished without a complete 40-bit frame on the SPI pins", name);
    end else if (last_word !== exp) begin
      read_errors++;
      $display("ERROR %s: expected %08h, actual %08h", name, exp, last_word);
    end
    frames_taken = frames_done;
  endtask

  // Expected high counts packed a1, a2, b1, b2 from the top byte
  task automatic check_duty(input string name, input logic [31:0] exp);
    int         high [4];
    logic [3:0] pins;
    string      names [4] = '{"a1", "a2", "b1", "b2"};
    for (int k = 0; k < 4; k++)
      high[k] = 0;
    repeat (2 * `MOTOR_PWM_PERIOD) @(negedge CLK);  // New amplitude latched by now
    // Any 256-cycle window covers exactly one PWM period
    repeat (`MOTOR_PWM_PERIOD) begin
      @(negedge CLK);
      pins = {phase_a1, phase_a2, phase_b1, phase_b2};
      for (int k = 0; k < 4; k++)
        if (pins[3 - k])
          high[k]++;
    end
    checks++;
    for (int k = 0; k < 4; k++) begin
      if (high[k] != int'(exp[31 - 8 * k -: 8])) begin
        duty_errors++;
        $display("ERROR %s pin %s: expected %0d, actual %0d",
                 name, names[k], exp[31 - 8 * k -: 8], high[k]);
      end
    end
  endtask

endmodule

// ==== dv/motor_core_tb.sv ====
`timescale 1ns/1ps
`include "motor_consts.svh"

module motor_core_tb;

  typedef enum int {
    k_write, k_short, k_read, k_read_pos, k_read_enc,
    k_step, k_enc, k_glitch, k_pin, k_duty
  } row_kind_t;

  typedef struct {
    string       name;
    row_kind_t   kind;
    logic [7:0]  a0;   // Opcode, dir or pin level
    logic [31:0] a1;   // Write data or count, 0 picks a random count
    logic [31:0] exp;
  } row_t;

  logic CLK;
  logic resetn;
  logic sck;
  logic cs;
  logic copi;
  logic step;
  logic dir;
  logic enable;
  logic enc_a;
  logic enc_b;
  logic cipo;
  logic phase_a1;
  logic phase_a2;
  logic phase_b1;
  logic phase_b2;

  row_t        rows[$];
  int          limit = 0;
  logic [31:0] lfsr;
  int          model_pos = 0;
  int          model_enc = 0;
  logic        model_de = 1'b0;
  logic        model_pin_en = 1'b0;
  int          gray_idx = 0;
  logic [1:0]  gray [4] = '{2'b00, 2'b10, 2'b11, 2'b01};  // Count-up order, A leads B

  tb_clock clk_gen (.CLK(CLK), .resetn(resetn));

  motor_core dut (
    .CLK(CLK), .resetn(resetn), .sck(sck), .cs(cs), .copi(copi),
    .step(step), .dir(dir), .enable(enable), .enc_a(enc_a), .enc_b(enc_b),
    .cipo(cipo), .phase_a1(phase_a1), .phase_a2(phase_a2),
    .phase_b1(phase_b1), .phase_b2(phase_b2)
  );

  motor_checker chk (
    .CLK(CLK), .sck(sck), .cs(cs), .cipo(cipo), .phase_a1(phase_a1),
    .phase_a2(phase_a2), .phase_b1(phase_b1), .phase_b2(phase_b2)
  );

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // Taps 32, 22, 2, 1
  endfunction

  function automatic int take_bits(input int n);
    int val;
    val = 0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      val = (val << 1) | int'(lfsr[0]);
    end
    return val;
  endfunction

  function automatic void add_row(input string name, input row_kind_t kind,
                                  input logic [7:0] a0, input logic [31:0] a1,
                                  input logic [31:0] exp);
    row_t r;
    r.name = name;
    r.kind = kind;
    r.a0 = a0;
    r.a1 = a1;
    r.exp = exp;
    rows.push_back(r);
  endfunction

  function automatic int row_bound(input row_kind_t kind);
    case (kind)
      k_step:          return 8 + 8 * 16 + 16;
      k_enc:           return 5 * 32 + 16;
      k_glitch, k_pin: return 16;
      k_duty:          return 3 * `MOTOR_PWM_PERIOD + 16;
      default:         return 20 * 44;  // One SPI frame at 10 clocks per half cycle
    endcase
  endfunction

  // Duty rows pack a1, a2, b1, b2 high counts from the top byte
  function automatic void build_table();
    add_row("cfg_current", k_write, `MOTOR_OP_SET_CURRENT, 32'd100, 32'd0);
    add_row("cfg_ustep_clamp", k_write, `MOTOR_OP_SET_MICROSTEPS, 32'd9, 32'd0);
    add_row("cfg_read_clamp", k_read, `MOTOR_OP_READ_CONFIG, 32'd0, 32'h0000_0664);
    add_row("cfg_ustep", k_write, `MOTOR_OP_SET_MICROSTEPS, 32'd2, 32'd0);
    add_row("cfg_enable", k_write, `MOTOR_OP_SET_DRIVE_ENABLE, 32'd1, 32'd0);
    add_row("cfg_short", k_short, `MOTOR_OP_SET_CURRENT, 32'd7, 32'd0);
    add_row("cfg_read", k_read, `MOTOR_OP_READ_CONFIG, 32'd0, 32'h0001_0264);
    add_row("pin_on", k_pin, 8'd1, 32'd0, 32'd0);
    add_row("status_on", k_read, `MOTOR_OP_READ_STATUS, 32'd0, 32'd2);
    add_row("duty_0", k_duty, 8'd0, 32'd0, 32'h6400_0000);
    add_row("step_to_64", k_step, 8'd1, 32'd4, 32'd0);
    add_row("duty_64", k_duty, 8'd0, 32'd0, 32'h0000_6400);
    add_row("ustep_0", k_write, `MOTOR_OP_SET_MICROSTEPS, 32'd0, 32'd0);
    add_row("step_to_128", k_step, 8'd1, 32'd1, 32'd0);
    add_row("duty_128", k_duty, 8'd0, 32'd0, 32'h0064_0000);
    add_row("ustep_1", k_write, `MOTOR_OP_SET_MICROSTEPS, 32'd1, 32'd0);
    add_row("step_to_192", k_step, 8'd1, 32'd2, 32'd0);
    add_row("duty_192", k_duty, 8'd0, 32'd0, 32'h0000_0064);
    add_row("cur_200", k_write, `MOTOR_OP_SET_CURRENT, 32'd200, 32'd0);
    add_row("step_back_0", k_step, 8'd0, 32'd6, 32'd0);
    add_row("duty_back_0", k_duty, 8'd0, 32'd0, 32'hc800_0000);
    add_row("pos_fixed", k_read_pos, 8'd0, 32'd0, 32'd0);
    add_row("steps_up", k_step, 8'd1, 32'd0, 32'd0);
    add_row("steps_down", k_step, 8'd0, 32'd0, 32'd0);
    add_row("pos_random", k_read_pos, 8'd0, 32'd0, 32'd0);
    add_row("enc_fwd", k_enc, 8'd1, 32'd0, 32'd0);
    add_row("enc_rev", k_enc, 8'd0, 32'd0, 32'd0);
    add_row("enc_read", k_read_enc, 8'd0, 32'd0, 32'd0);
    add_row("enc_status_ok", k_read, `MOTOR_OP_READ_STATUS, 32'd0, 32'd2);
    add_row("enc_glitch", k_glitch, 8'd0, 32'd0, 32'd0);
    add_row("enc_status_fault", k_read, `MOTOR_OP_READ_STATUS, 32'd0, 32'd3);
    add_row("enc_read_hold", k_read_enc, 8'd0, 32'd0, 32'd0);
    add_row("de_off", k_write, `MOTOR_OP_SET_DRIVE_ENABLE, 32'd0, 32'd0);
    add_row("duty_de_off", k_duty, 8'd0, 32'd0, 32'd0);
    add_row("steps_de_off", k_step, 8'd1, 32'd3, 32'd0);
    add_row("pos_de_off", k_read_pos, 8'd0, 32'd0, 32'd0);
    add_row("status_de_off", k_read, `MOTOR_OP_READ_STATUS, 32'd0, 32'd1);
    add_row("de_on", k_write, `MOTOR_OP_SET_DRIVE_ENABLE, 32'd1, 32'd0);
    add_row("pin_off", k_pin, 8'd0, 32'd0, 32'd0);
    add_row("duty_pin_off", k_duty, 8'd0, 32'd0, 32'd0);
    add_row("steps_pin_off", k_step, 8'd0, 32'd3, 32'd0);
    add_row("pos_pin_off", k_read_pos, 8'd0, 32'd0, 32'd0);
    add_row("status_pin_off", k_read, `MOTOR_OP_READ_STATUS, 32'd0, 32'd1);
  endfunction

  task automatic wait_clks(input int n);
    repeat (n) @(posedge CLK);
    #2;
  endtask

  task automatic spi_frame(input logic [7:0] op, input logic [31:0] data, input int nbits);
    logic [39:0] word;
    word = {op, data};
    cs = 1'b0;
    for (int i = 0; i < nbits; i++) begin
      copi = word[39 - i];
      wait_clks(10);  // Half SCK period
      sck = 1'b1;
      wait_clks(10);
      sck = 1'b0;
    end
    copi = 1'b0;
    wait_clks(10);
    cs = 1'b1;
    wait_clks(10);
  endtask

  task automatic send_steps(input logic up, input int n);
    dir = up;
    wait_clks(4);
    repeat (n) begin
      step = 1'b1;
      wait_clks(4);
      step = 1'b0;
      wait_clks(4);
    end
    if (model_pin_en && model_de)
      model_pos = up ? model_pos + n : model_pos - n;
  endtask

  task automatic send_enc(input logic up, input int n);
    repeat (n) begin
      gray_idx = up ? (gray_idx + 1) % 4 : (gray_idx + 3) % 4;
      {enc_a, enc_b} = gray[gray_idx];
      wait_clks(5);
    end
    model_enc = up ? model_enc + n : model_enc - n;
  endtask

  task automatic run_row(input row_t r);
    int n;
    case (r.kind)
      k_write: begin
        spi_frame(r.a0, r.a1, `MOTOR_FRAME_BITS);
        if (r.a0 == `MOTOR_OP_SET_DRIVE_ENABLE)
          model_de = r.a1[0];
      end
      k_short: spi_frame(r.a0, r.a1, `MOTOR_FRAME_BITS - 1);
      k_read: begin
        spi_frame(r.a0, 32'd0, `MOTOR_FRAME_BITS);
        chk.check_read(r.name, r.exp);
      end
      k_read_pos: begin
        spi_frame(`MOTOR_OP_READ_POSITION, 32'd0, `MOTOR_FRAME_BITS);
        chk.check_read(r.name, model_pos);
      end
      k_read_enc: begin
        spi_frame(`MOTOR_OP_READ_ENCODER, 32'd0, `MOTOR_FRAME_BITS);
        chk.check_read(r.name, model_enc);
      end
      k_step: begin
        n = (r.a1 != 0) ? int'(r.a1) : 1 + take_bits(4);
        send_steps(r.a0[0], n);
      end
      k_enc: begin
        n = (r.a1 != 0) ? int'(r.a1) : 1 + take_bits(5);
        send_enc(r.a0[0], n);
      end
      k_glitch: begin
        gray_idx = (gray_idx + 2) % 4;  // Both pins flip, count holds
        {enc_a, enc_b} = gray[gray_idx];
        wait_clks(5);
      end
      k_pin: begin
        enable = r.a0[0];
        model_pin_en = r.a0[0];
        wait_clks(4);
      end
      k_duty: begin
        chk.check_duty(r.name, r.exp);
        wait_clks(1);  // Back in step with the drive edge
      end
      default: ;
    endcase
  endtask

  initial begin
    wait (limit > 0);
    repeat (limit) @(posedge CLK);
    $display("Watchdog expired after %0d clock cycles before the tests finished", limit);
    $display("Some tests failed");
    $finish;
  end

  initial begin
    int total;
    sck = 1'b0;
    cs = 1'b1;
    copi = 1'b0;
    step = 1'b0;
    dir = 1'b0;
    enable = 1'b0;
    enc_a = 1'b0;
    enc_b = 1'b0;
    lfsr = 32'hab198e88;
    build_table();
    total = 1000;  // Reset and margin
    foreach (rows[i])
      total += row_bound(rows[i].kind);
    limit = total;
    @(posedge resetn);
    wait_clks(5);
    foreach (rows[i])
      run_row(rows[i]);
    $display("Checks run: %0d, read errors: %0d, duty errors: %0d",
             chk.checks, chk.read_errors, chk.duty_errors);
    if (chk.read_errors + chk.duty_errors == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

endmodule

// ==== all.f ====
+incdir+include
source/motor_pkg.sv
source/spi_cmd_port.sv
source/step_sequencer.sv
source/quad_decoder.sv
source/phase_driver.sv
source/motor_core.sv
dv/tb_clock.sv
dv/motor_checker.sv
dv/motor_core_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the motor core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f all.f --top-module motor_core_tb \
  -o motor_sim > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "Verilator build failed, see build.log"
  exit 1
fi

./obj_dir/motor_sim > sim.log 2>&1
if [ $? -ne 0 ]; then
  echo "Simulation exited with an error, see sim.log"
  exit 1
fi

if grep -q "^All tests passed$" sim.log; then
  echo "PASS"
  exit 0
else
  echo "FAIL, see sim.log"
  exit 1
fi
